// File: Bender.yml
package:
  name: rob_store

export_include_dirs:
  - hdl

sources:
  - hdl/rob_pkg.sv
  - hdl/rob_table.sv
  - hdl/has_previous_fc.sv
  - hdl/has_previous_store.sv
  - hdl/axil_chan_reg.sv
  - hdl/store_release.sv
  - hdl/rob_store_top.sv
  - target: test
    files:
      - tests/rob_store_chk.sv
      - tests/rob_store_tb.sv

// File: flist.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_table.sv
hdl/has_previous_fc.sv
hdl/has_previous_store.sv
hdl/axil_chan_reg.sv
hdl/store_release.sv
hdl/rob_store_top.sv
tests/rob_store_chk.sv
tests/rob_store_tb.sv

// File: hdl/axil_chan_reg.sv
// ============================================================
// Holding register for one AXI4-Lite request channel
// Load only while busy is low, the payload is not replaced
// while valid waits for ready
// ============================================================

module axil_chan_reg
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load,
	input  payload_t load_data,
	output logic     busy,
	output logic     valid,
	input  logic     ready,
	output payload_t data
);

	// A channel is busy for exactly as long as it presents valid
	assign busy = valid;

	// Valid rises the cycle after load and drops after the handshake.
	// A load in the same cycle as the handshake keeps it high
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid <= 1'b0;
		else if (load)
			valid <= 1'b1;
		else if (ready)
			valid <= 1'b0;
	end

	// Payload is captured on load and then held until the next load
	always_ff @(posedge clk)
	begin
		if (load)
			data <= load_data;
	end

endmodule

// File: hdl/has_previous_fc.sv
// ============================================================
// Combinational check for an older unresolved branch
// Relies on sequence numbers that never wrap
// ============================================================
`include "rob_defs.svh"

module has_previous_fc
(
	input  rob_pkg::rob_ndx_t                      id,
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output logic                                   has_previous_fc
);

	// A store may not reach memory while program flow can still change.
	// Any valid FC op older than entry id that is not fully done blocks it
	always_comb
	begin
		has_previous_fc = 1'b0;
		for (int n = 0; n < `ROB_ENTRIES; n++)
		begin
			// Entry id itself never matches since its sn is not less than its own
			if (rob[n].v &&
				rob[n].kind == rob_pkg::OP_FC &&
				rob[n].sn < rob[id].sn &&
				rob[n].done != 2'b11)
				has_previous_fc = 1'b1;
		end
	end

endmodule

// File: hdl/has_previous_store.sv
// ============================================================
// Combinational check for an older store not yet written
// Keeps memory writes in program order
// Relies on sequence numbers that never wrap
// ============================================================
`include "rob_defs.svh"

module has_previous_store
(
	input  rob_pkg::rob_ndx_t                      id,
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output logic                                   has_previous_store
);

	// An older store blocks this one until its B response has set done[1].
	// A store that has not even executed yet blocks as well, so a young
	// store can never overtake an older one on the bus
	always_comb
	begin
		has_previous_store = 1'b0;
		for (int n = 0; n < `ROB_ENTRIES; n++)
		begin
			if (rob[n].v &&
				rob[n].kind == rob_pkg::OP_STORE &&
				rob[n].sn < rob[id].sn &&
				rob[n].done != 2'b11)
				has_previous_store = 1'b1;
		end
	end

endmodule

// File: hdl/rob_defs.svh
// ============================================================
// Sizes shared by the ROB store-release design
// ROB_ENTRIES must be a power of two, the pointers wrap freely
// Sequence numbers are not allowed to wrap within one run
// ============================================================
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Number of slots in the reorder buffer
`define ROB_ENTRIES 8

// Width of the monotonic sequence number given at dispatch
`define SN_W 8

// Store address width, also the AXI4-Lite AWADDR width
`define ADDR_W 32

// Store data width, also the AXI4-Lite WDATA width
// The write strobe in rob_pkg assumes four byte lanes
`define DATA_W 32

`endif

// File: hdl/rob_pkg.sv
// ============================================================
// Types for the ROB table, the detectors and the AXI writes
// The strobe is fixed at four bits, so DATA_W must stay 32
// ============================================================
`include "rob_defs.svh"

package rob_pkg;

	// Index of one ROB slot
	typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_ndx_t;

	// Sequence number, smaller means older in program order
	typedef logic [`SN_W-1:0] seqnum_t;

	// Kind of micro-op held in a slot
	typedef enum logic [1:0] {
		OP_ALU   = 2'd0,
		OP_FC    = 2'd1,
		OP_STORE = 2'd2
	} op_kind_t;

	// One ROB slot
	// done[0] is set on execute, done[1] on branch resolve or store write
	typedef struct packed {
		logic                v;
		seqnum_t             sn;
		op_kind_t            kind;
		logic [1:0]          done;
		logic [`ADDR_W-1:0]  addr;
		logic [`DATA_W-1:0]  data;
	} rob_entry_t;

	// Dispatch request, the sequence number is given by the table
	typedef struct packed {
		op_kind_t            kind;
		logic [`ADDR_W-1:0]  addr;
		logic [`DATA_W-1:0]  data;
	} dispatch_t;

	// Completion request, mask is ORed into done of slot id
	typedef struct packed {
		rob_ndx_t            id;
		logic [1:0]          mask;
	} complete_t;

	// AXI4-Lite write address payload
	typedef struct packed {
		logic [`ADDR_W-1:0]  addr;
		logic [2:0]          prot;
	} aw_t;

	// AXI4-Lite write data payload
	typedef struct packed {
		logic [`DATA_W-1:0]  data;
		logic [3:0]          strb;
	} w_t;

endpackage

// File: hdl/rob_store_top.sv
// ============================================================
// ROB with in-order store release over AXI4-Lite writes
// bready is tied high and bresp is not checked
// Dispatch is only legal while full is low
// ============================================================
`include "rob_defs.svh"

module rob_store_top
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 disp_valid,
	input  rob_pkg::dispatch_t   disp,
	output rob_pkg::rob_ndx_t    disp_id,
	input  logic                 cpl_valid,
	input  rob_pkg::complete_t   cpl,
	output logic                 full,
	output logic                 commit,
	output rob_pkg::seqnum_t     commit_sn,
	output logic                 awvalid,
	input  logic                 awready,
	output logic [`ADDR_W-1:0]   awaddr,
	output logic [2:0]           awprot,
	output logic                 wvalid,
	input  logic                 wready,
	output logic [`DATA_W-1:0]   wdata,
	output logic [3:0]           wstrb,
	input  logic                 bvalid,
	output logic                 bready,
	input  logic [1:0]           bresp
);

	rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob;
	rob_pkg::rob_ndx_t cand_id;
	logic has_previous_fc;
	logic has_previous_store;
	logic aw_load;
	logic w_load;
	rob_pkg::aw_t aw_payload;
	rob_pkg::w_t w_payload;
	rob_pkg::aw_t aw_q;
	rob_pkg::w_t w_q;
	logic aw_busy;
	logic w_busy;
	logic wr_done_valid;
	rob_pkg::rob_ndx_t wr_done_id;
	logic b_seen;

	// Responses are always accepted, any bresp value counts as done
	assign bready = 1'b1;
	assign b_seen = bvalid && bready;

	rob_table u_table (.clk, .rst_n, .disp_valid, .disp, .disp_id, .full, .cpl_valid, .cpl,
		.wr_done_valid, .wr_done_id, .rob, .commit, .commit_sn);

	// ============================================================
	// Release rule
	// ============================================================
	// Both detectors look at the same candidate in parallel
	has_previous_fc u_fc (.id(cand_id), .rob, .has_previous_fc);
	has_previous_store u_st (.id(cand_id), .rob, .has_previous_store);

	store_release u_rel (.clk, .rst_n, .rob, .cand_id, .has_previous_fc, .has_previous_store,
		.aw_load, .aw_payload, .w_load, .w_payload, .bvalid(b_seen), .wr_done_valid,
		.wr_done_id);

	// A channel still waiting for ready never takes a new payload
	axil_chan_reg #(.payload_t(rob_pkg::aw_t)) u_aw (.clk, .rst_n,
		.load(aw_load && !aw_busy), .load_data(aw_payload), .busy(aw_busy),
		.valid(awvalid), .ready(awready), .data(aw_q));

	axil_chan_reg #(.payload_t(rob_pkg::w_t)) u_w (.clk, .rst_n,
		.load(w_load && !w_busy), .load_data(w_payload), .busy(w_busy),
		.valid(wvalid), .ready(wready), .data(w_q));

	assign awaddr = aw_q.addr;
	assign awprot = aw_q.prot;
	assign wdata = w_q.data;
	assign wstrb = w_q.strb;

endmodule

// File: hdl/rob_table.sv
// ============================================================
// Circular ROB with dispatch at the tail and retire at the head
// The driver must not dispatch while full is high
// Retirement is one entry per cycle, with no flush support
// ============================================================
`include "rob_defs.svh"

module rob_table
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   disp_valid,
	input  rob_pkg::dispatch_t                     disp,
	output rob_pkg::rob_ndx_t                      disp_id,
	output logic                                   full,
	input  logic                                   cpl_valid,
	input  rob_pkg::complete_t                     cpl,
	input  logic                                   wr_done_valid,
	input  rob_pkg::rob_ndx_t                      wr_done_id,
	output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output logic                                   commit,
	output rob_pkg::seqnum_t                       commit_sn
);

	// Occupancy must be able to hold the value ROB_ENTRIES itself
	localparam int CNT_W = $clog2(`ROB_ENTRIES + 1);

	rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] slot;
	logic [`ROB_ENTRIES-1:0] vld;
	rob_pkg::rob_ndx_t head;
	rob_pkg::rob_ndx_t tail;
	logic [CNT_W-1:0] count;
	rob_pkg::seqnum_t next_sn;
	logic disp_go;

	// The new op lands at the tail, its index is known at once
	assign disp_id = tail;
	assign full = count == CNT_W'(`ROB_ENTRIES);
	assign disp_go = disp_valid && !full;

	// Slot contents with the valid bits taken from the reset register
	always_comb
	begin
		for (int i = 0; i < `ROB_ENTRIES; i++)
		begin
			rob[i] = slot[i];
			rob[i].v = vld[i];
		end
	end

	// The head retires as soon as both done bits are set
	assign commit = rob[head].v && rob[head].done == 2'b11;
	assign commit_sn = rob[head].sn;

	// ============================================================
	// Slot payload
	// ============================================================
	always_ff @(posedge clk)
	begin
		// Completion from the execute side ORs in its mask
		if (cpl_valid)
			slot[cpl.id].done <= slot[cpl.id].done | cpl.mask;
		// Store write finished on the bus, mark it written
		if (wr_done_valid)
			slot[wr_done_id].done[1] <= 1'b1;
		// A slot being dispatched is never the target of the two above
		if (disp_go)
			slot[tail] <= '{v: 1'b1, sn: next_sn, kind: disp.kind, done: 2'b00,
				addr: disp.addr, data: disp.data};
	end

	// ============================================================
	// Pointers, occupancy and sequence counter
	// ============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vld <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			next_sn <= '0;
		end
		else
		begin
			if (commit)
			begin
				vld[head] <= 1'b0;
				head <= rob_pkg::rob_ndx_t'(head + 1'b1);
			end
			// When full the tail equals the head, but dispatch is blocked then
			if (disp_go)
			begin
				vld[tail] <= 1'b1;
				tail <= rob_pkg::rob_ndx_t'(tail + 1'b1);
				next_sn <= rob_pkg::seqnum_t'(next_sn + 1'b1);
			end
			case ({disp_go, commit})
				2'b10: count <= CNT_W'(count + 1'b1);
				2'b01: count <= CNT_W'(count - 1'b1);
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/store_release.sv
// ============================================================
// Releases the oldest eligible store to the AXI4-Lite write side
// Only one write is outstanding at a time
// The response code is ignored, every B marks the store written
// ============================================================
`include "rob_defs.svh"

module store_release
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output rob_pkg::rob_ndx_t                      cand_id,
	input  logic                                   has_previous_fc,
	input  logic                                   has_previous_store,
	output logic                                   aw_load,
	output rob_pkg::aw_t                           aw_payload,
	output logic                                   w_load,
	output rob_pkg::w_t                            w_payload,
	input  logic                                   bvalid,
	output logic                                   wr_done_valid,
	output rob_pkg::rob_ndx_t                      wr_done_id
);

	logic cand_found;
	rob_pkg::seqnum_t best_sn;
	logic in_flight;
	logic release_go;
	rob_pkg::rob_ndx_t fly_id;

	// ============================================================
	// Candidate selection
	// ============================================================
	// Oldest valid store whose address and data are ready but which has
	// not been written yet. While a store is in flight it stays the
	// candidate itself, because it is the oldest such store until its
	// write-done lands, so the in_flight gate below covers it
	always_comb
	begin
		cand_found = 1'b0;
		cand_id = '0;
		best_sn = '0;
		for (int n = 0; n < `ROB_ENTRIES; n++)
		begin
			if (rob[n].v && rob[n].kind == rob_pkg::OP_STORE && rob[n].done == 2'b01 &&
				(!cand_found || rob[n].sn < best_sn))
			begin
				cand_found = 1'b1;
				cand_id = rob_pkg::rob_ndx_t'(n);
				best_sn = rob[n].sn;
			end
		end
	end

	// Both detectors answer for cand_id in this same cycle
	assign release_go = cand_found && !in_flight && !has_previous_fc && !has_previous_store;
	assign aw_load = release_go;
	assign w_load = release_go;

	// Plain data access, unprivileged and secure, all four byte lanes written
	always_comb
	begin
		aw_payload.addr = rob[cand_id].addr;
		aw_payload.prot = 3'b000;
		w_payload.data = rob[cand_id].data;
		w_payload.strb = 4'hf;
	end

	// ============================================================
	// In-flight tracking and write-done
	// ============================================================
	// in_flight stays set until the write-done has reached the table,
	// otherwise the store would be picked again with done still 2'b01
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			in_flight <= 1'b0;
			wr_done_valid <= 1'b0;
		end
		else
		begin
			wr_done_valid <= bvalid && in_flight && !wr_done_valid;
			if (release_go)
				in_flight <= 1'b1;
			else if (wr_done_valid)
				in_flight <= 1'b0;
		end
	end

	// Index of the store on the bus
	always_ff @(posedge clk)
	begin
		if (release_go)
			fly_id <= cand_id;
	end

	assign wr_done_id = fly_id;

endmodule

// File: tests/rob_store_chk.sv
// ============================================================
// AXI4-Lite write handshake and release rule assertions
// Bound into rob_store_top, sampled on the rising clock edge
// ============================================================
`include "rob_defs.svh"

module rob_store_chk
(
	input logic               clk,
	input logic               rst_n,
	input logic               awvalid,
	input logic               awready,
	input logic [`ADDR_W-1:0] awaddr,
	input logic               wvalid,
	input logic               wready,
	input logic [`DATA_W-1:0] wdata,
	input logic               has_previous_fc
);
	timeunit 1ns;
	timeprecision 100ps;

	// AW must hold valid and address until the slave takes it
	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid dropped or awaddr changed before awready");

	// Same rule on the write data channel
	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else $error("wvalid dropped or wdata changed before wready");

	// The release cycle is the one before the rise, no older branch may be open then
	aw_fc_rule: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(awvalid) |-> !$past(has_previous_fc))
		else $error("awvalid rose while an older FC op was unresolved");

endmodule

bind rob_store_top rob_store_chk chk0 (.clk, .rst_n, .awvalid, .awready, .awaddr,
	.wvalid, .wready, .wdata, .has_previous_fc);

// File: tests/rob_store_tb.sv
// ============================================================
// Random testbench for the ROB store release over AXI4-Lite
// Sequence numbers start at zero, so op i carries sn i
// Fewer than 256 ops are issued, the sn never wraps
// ============================================================
`include "rob_defs.svh"

module rob_store_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_OPS = 64;
	localparam int PER_OP_CYCLES = 40;

	logic clk;
	logic rst_n;
	logic disp_valid;
	rob_pkg::dispatch_t disp;
	rob_pkg::rob_ndx_t disp_id;
	logic cpl_valid;
	rob_pkg::complete_t cpl;
	logic full;
	logic commit;
	rob_pkg::seqnum_t commit_sn;
	logic awvalid;
	logic awready;
	logic [`ADDR_W-1:0] awaddr;
	logic [2:0] awprot;
	logic wvalid;
	logic wready;
	logic [`DATA_W-1:0] wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;

	// Program of ops, generated before reset
	rob_pkg::op_kind_t op_kind [N_OPS];
	logic [31:0] op_addr [N_OPS];
	logic [31:0] op_data [N_OPS];
	rob_pkg::rob_ndx_t op_id [N_OPS];
	// Cycle of completion per op, -1 while still pending
	int op_cpl [N_OPS];
	int store_op [$];
	int pend [$];
	int b_cyc [$];
	int cyc = 0;
	int occ = 0;
	int n_cpl = 0;
	int n_commit = 0;
	int st_commit = 0;
	int rise_cnt = 0;
	int aw_cnt = 0;
	int w_cnt = 0;
	int b_sent = 0;
	logic aw_prev = 1'b0;
	logic [31:0] rng;
	logic [31:0] srng;

	rob_store_top dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// ============================================================
	// Reference model
	// ============================================================
	// Cycle in which awvalid of the s-th store must rise, -1 if it is
	// still blocked. The store goes 2 cycles after its own completion or
	// after the last older FC completion, and 3 cycles after the B of
	// the store before it, whichever is latest
	function automatic int release_cycle(input int s);
		int op;
		int t;
		op = store_op[s];
		if (op_cpl[op] < 0)
			return -1;
		t = op_cpl[op] + 2;
		for (int i = 0; i < op; i++)
		begin
			if (op_kind[i] == rob_pkg::OP_FC)
			begin
				if (op_cpl[i] < 0)
					return -1;
				if (op_cpl[i] + 2 > t)
					t = op_cpl[i] + 2;
			end
		end
		if (s > 0)
		begin
			if (b_cyc.size() < s)
				return -1;
			if (b_cyc[s-1] + 3 > t)
				t = b_cyc[s-1] + 3;
		end
		return t;
	endfunction

	// ============================================================
	// Dispatch and completion driver
	// ============================================================
	initial
	begin
		int nd;
		int j;
		int op;
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp = '0;
		cpl_valid = 1'b0;
		cpl = '0;
		rng = 32'd67;
		for (int i = 0; i < N_OPS; i++)
		begin
			rng = xorshift(rng);
			op_kind[i] = rob_pkg::op_kind_t'(rng % 3);
			rng = xorshift(rng);
			op_addr[i] = {rng[31:2], 2'b00};
			rng = xorshift(rng);
			op_data[i] = rng;
			op_cpl[i] = -1;
			if (op_kind[i] == rob_pkg::OP_STORE)
				store_op.push_back(i);
		end
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		nd = 0;
		while (n_cpl < N_OPS)
		begin
			@(posedge clk);
			#1;
			disp_valid = 1'b0;
			cpl_valid = 1'b0;
			rng = xorshift(rng);
			// Complete a random pending op, so the order differs from dispatch
			if (pend.size() > 0 && rng[0])
			begin
				j = rng[15:8] % pend.size();
				op = pend[j];
				pend.delete(j);
				cpl_valid = 1'b1;
				cpl.id = op_id[op];
				cpl.mask = (op_kind[op] == rob_pkg::OP_STORE) ? 2'b01 : 2'b11;
				op_cpl[op] = cyc;
				n_cpl++;
			end
			if (nd < N_OPS && !full && rng[2:1] != 2'b00)
			begin
				disp_valid = 1'b1;
				disp.kind = op_kind[nd];
				disp.addr = op_addr[nd];
				disp.data = op_data[nd];
				// Slots fill in order around the ring, starting from slot 0
				assert (disp_id == rob_pkg::rob_ndx_t'(nd % `ROB_ENTRIES))
				else abort_run($sformatf("** Error disp_id: got %h, expected %h", disp_id,
					rob_pkg::rob_ndx_t'(nd % `ROB_ENTRIES)));
				op_id[nd] = disp_id;
				pend.push_back(nd);
				nd++;
			end
		end
		@(posedge clk);
		#1;
		disp_valid = 1'b0;
		cpl_valid = 1'b0;
		wait (n_commit == N_OPS);
		@(negedge clk);
		if (aw_cnt == store_op.size() && w_cnt == store_op.size() &&
			b_cyc.size() == store_op.size())
		begin
			$display("TEST OK");
			$finish;
		end
		else
			abort_run("all ops committed but the number of writes is wrong");
	end

	// ============================================================
	// AXI4-Lite write slave with random stalls
	// ============================================================
	initial
	begin
		logic b_armed;
		int b_wait;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'b00;
		b_armed = 1'b0;
		b_wait = 0;
		srng = xorshift(32'd67);
		@(posedge rst_n);
		forever
		begin
			@(posedge clk);
			#1;
			srng = xorshift(srng);
			// Each ready is low about one cycle in four
			awready = srng[1:0] != 2'b00;
			wready = srng[3:2] != 2'b00;
			bvalid = 1'b0;
			if (!b_armed && aw_cnt > b_sent && w_cnt > b_sent)
			begin
				b_armed = 1'b1;
				b_wait = srng[5:4] % 3;
			end
			if (b_armed)
			begin
				if (b_wait == 0)
				begin
					bvalid = 1'b1;
					b_armed = 1'b0;
					b_sent++;
				end
				else
					b_wait--;
			end
		end
	end

	// ============================================================
	// Comparison at the falling edge, where outputs are settled
	// ============================================================
	always @(negedge clk)
	begin
		int exp_t;
		if (rst_n)
		begin
			assert (full == (occ == `ROB_ENTRIES))
			else abort_run($sformatf("** Error full: got %h, expected %h", full,
				occ == `ROB_ENTRIES));
			assert (bready == 1'b1)
			else abort_run($sformatf("** Error bready: got %h, expected %h", bready, 1'b1));
			if (disp_valid && !full)
				occ++;
			if (commit)
			begin
				assert (n_commit < N_OPS) else abort_run("commit seen after the last op");
				assert (commit_sn == rob_pkg::seqnum_t'(n_commit))
				else abort_run($sformatf("** Error commit_sn: got %h, expected %h",
					commit_sn, rob_pkg::seqnum_t'(n_commit)));
				// A store retires no earlier than 2 cycles after its B
				if (op_kind[n_commit] == rob_pkg::OP_STORE)
				begin
					assert (b_cyc.size() > st_commit && cyc >= b_cyc[st_commit] + 2)
					else abort_run("a store committed before its write response");
					st_commit++;
				end
				n_commit++;
				occ--;
			end
			if (awvalid && !aw_prev)
			begin
				assert (rise_cnt < store_op.size()) else abort_run("awvalid rose with no store left");
				exp_t = release_cycle(rise_cnt);
				assert (exp_t >= 0)
				else abort_run("awvalid rose while the store was incomplete or blocked");
				assert (cyc == exp_t)
				else abort_run($sformatf("** Error awvalid rise cycle: got %h, expected %h",
					cyc, exp_t));
				rise_cnt++;
			end
			aw_prev = awvalid;
			if (awvalid && awready)
			begin
				assert (aw_cnt < store_op.size()) else abort_run("extra write address seen");
				assert (awaddr == op_addr[store_op[aw_cnt]])
				else abort_run($sformatf("** Error awaddr: got %h, expected %h", awaddr,
					op_addr[store_op[aw_cnt]]));
				// Plain unprivileged secure data access
				assert (awprot == 3'b000)
				else abort_run($sformatf("** Error awprot: got %h, expected %h", awprot,
					3'b000));
				aw_cnt++;
			end
			if (wvalid && wready)
			begin
				assert (w_cnt < store_op.size()) else abort_run("extra write data seen");
				assert (wdata == op_data[store_op[w_cnt]])
				else abort_run($sformatf("** Error wdata: got %h, expected %h", wdata,
					op_data[store_op[w_cnt]]));
				// Every store writes the whole 32-bit word
				assert (wstrb == 4'hf)
				else abort_run($sformatf("** Error wstrb: got %h, expected %h", wstrb, 4'hf));
				w_cnt++;
			end
			if (bvalid)
				b_cyc.push_back(cyc);
		end
	end

	// Every op gets a fixed cycle budget, on top of the reset time
	initial
	begin
		#((16 + N_OPS * PER_OP_CYCLES) * 10);
		abort_run("watchdog expired before all ops committed");
	end

endmodule
